/* afu_subsys.f */
design/afu_pkg.sv
design/ap_ctrl_if.sv
design/afu_ctrl.sv
design/dcr_regfile.sv
design/kernel_engine.sv
design/afu_top.sv
tb/tb_clock_gen.sv
tb/afu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the afu testbench with verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module afu_tb -f afu_subsys.f -o afu_tb_sim \
    || { echo "verilator build failed"; exit 1; }

output="$(./obj_dir/afu_tb_sim)"
echo "$output"

echo "$output" | grep -qx "Testbench passed" && exit 0 || exit 1

/* tb/afu_tb.sv */
/*
 * afu subsystem testbench
 * directed tests over the axi4-lite host port: capabilities, interrupts,
 * memory bases, kernel runs, auto-restart and response back-pressure
 */
`timescale 1ns/10ps

module afu_tb;

    localparam int NUM_BANKS     = 2;
    localparam int THREAD_CNT    = 4;
    localparam int CLK_PERIOD_NS = 20;
    // the tests take about 800 cycles, the watchdog allows some margin on top
    localparam int WATCHDOG_NS   = 1000 * CLK_PERIOD_NS;

    logic               clk;
    logic               reset;

    logic               awvalid;
    afu_pkg::addr_t     awaddr;
    logic               awready;
    logic               wvalid;
    afu_pkg::data_t     wdata;
    afu_pkg::strb_t     wstrb;
    logic               wready;
    logic               bvalid;
    logic [1:0]         bresp;
    logic               bready;
    logic               arvalid;
    afu_pkg::addr_t     araddr;
    logic               arready;
    logic               rvalid;
    afu_pkg::data_t     rdata;
    logic [1:0]         rresp;
    logic               rready;
    logic               interrupt;
    afu_pkg::mem_addr_t mem_base [NUM_BANKS];

    integer             seed;
    int                 data_errors;
    int                 caps_errors;
    int                 mem_errors;
    int                 bit_errors;
    int                 protocol_errors;

    // expected register state
    afu_pkg::mem_addr_t exp_mem [NUM_BANKS];
    logic               exp_gie;
    logic [1:0]         exp_isr;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD_NS),
        .RESET_CYCLES (8)
    ) tb_clock_gen_i (
        .clk   (clk),
        .reset (reset)
    );

    afu_top #(
        .NUM_BANKS  (NUM_BANKS),
        .THREAD_CNT (THREAD_CNT),
        .DCR_DEPTH  (4)
    ) afu_top_i (
        .clk       (clk),
        .reset     (reset),
        .awvalid   (awvalid),
        .awaddr    (awaddr),
        .awready   (awready),
        .wvalid    (wvalid),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wready    (wready),
        .bvalid    (bvalid),
        .bresp     (bresp),
        .bready    (bready),
        .arvalid   (arvalid),
        .araddr    (araddr),
        .arready   (arready),
        .rvalid    (rvalid),
        .rdata     (rdata),
        .rresp     (rresp),
        .rready    (rready),
        .interrupt (interrupt),
        .mem_base  (mem_base)
    );

    // offset of the low or high word of a bank base
    function automatic afu_pkg::addr_t mem_offset(input int bank, input int half);
        afu_pkg::addr_t base;
        base = (half == 0) ? afu_pkg::ADDR_MEM_0 : afu_pkg::ADDR_MEM_1;
        return afu_pkg::addr_t'(base + bank * afu_pkg::MEM_STRIDE);
    endfunction

    task automatic axi_write(input afu_pkg::addr_t addr, input afu_pkg::data_t data,
                             input afu_pkg::strb_t strb = '1, input int bdelay = 0);
        @(posedge clk);
        awvalid <= 1'b1;
        awaddr  <= addr;
        do @(negedge clk); while (!awready);
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        do @(negedge clk); while (!wready);
        @(posedge clk);
        wvalid <= 1'b0;
        do @(negedge clk); while (!bvalid);
        if (bresp !== 2'b00) begin
            $display("write to 0x%02h got response %0d instead of OKAY", addr, bresp);
            protocol_errors++;
        end
        // stalled bready: response held, no new address taken
        repeat (bdelay) begin
            @(negedge clk);
            if (!bvalid || awready) begin
                $display("write response to 0x%02h was not held while bready was low", addr);
                protocol_errors++;
            end
        end
        @(posedge clk);
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input afu_pkg::addr_t addr, output afu_pkg::data_t data,
                            input int rdelay = 0);
        @(posedge clk);
        arvalid <= 1'b1;
        araddr  <= addr;
        do @(negedge clk); while (!arready);
        @(posedge clk);
        arvalid <= 1'b0;
        do @(negedge clk); while (!rvalid);
        data = rdata;
        if (rresp !== 2'b00) begin
            $display("read of 0x%02h got response %0d instead of OKAY", addr, rresp);
            protocol_errors++;
        end
        repeat (rdelay) begin
            @(negedge clk);
            if (!rvalid || rdata !== data || arready) begin
                $display("read data of 0x%02h was not held while rready was low", addr);
                protocol_errors++;
            end
        end
        @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic check_data(input string what, input afu_pkg::data_t got,
                              input afu_pkg::data_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            data_errors++;
        end
    endtask

    // fields shown as cores/warps/threads/smem/impl
    task automatic check_caps(input string what, input afu_pkg::dev_caps_t got,
                              input afu_pkg::dev_caps_t exp);
        if (got.fields !== exp.fields) begin
            $display("ERROR at %0t: %s is %0d/%0d/%0d/%0d/%0d, expected %0d/%0d/%0d/%0d/%0d",
                     $time, what, got.fields.core_count, got.fields.warp_count,
                     got.fields.thread_count, got.fields.smem_log_size, got.fields.impl_id,
                     exp.fields.core_count, exp.fields.warp_count,
                     exp.fields.thread_count, exp.fields.smem_log_size, exp.fields.impl_id);
            caps_errors++;
        end
    endtask

    task automatic check_mem(input int bank, input afu_pkg::mem_addr_t exp);
        @(negedge clk);
        if (mem_base[bank] !== exp) begin
            $display("ERROR at %0t: mem_base[%0d] is 0x%016h, expected 0x%016h",
                     $time, bank, mem_base[bank], exp);
            mem_errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp);
        @(negedge clk);
        if (interrupt !== exp) begin
            $display("ERROR at %0t: %s, interrupt is %b, expected %b",
                     $time, what, interrupt, exp);
            bit_errors++;
        end
    endtask

    task automatic wait_interrupt();
        do @(negedge clk); while (interrupt !== 1'b1);
    endtask

    // toggle status bits, then read them back and check the interrupt line
    task automatic toggle_status(input logic [1:0] bits);
        afu_pkg::data_t rd;
        axi_write(afu_pkg::ADDR_ISR, afu_pkg::data_t'(bits));
        exp_isr = exp_isr ^ bits;
        axi_read(afu_pkg::ADDR_ISR, rd);
        check_data("isr after toggle", rd, afu_pkg::data_t'(exp_isr));
        check_bit("after isr toggle", exp_gie & (|exp_isr));
    endtask

    task automatic set_gie(input logic en);
        axi_write(afu_pkg::ADDR_GIE, afu_pkg::data_t'(en));
        exp_gie = en;
        check_bit("after gie write", exp_gie & (|exp_isr));
    endtask

    // write one half of a bank base and apply the byte mask to the model
    task automatic write_mem_word(input int bank, input int half, input afu_pkg::data_t data,
                                  input afu_pkg::strb_t strb, input int bdelay);
        axi_write(mem_offset(bank, half), data, strb, bdelay);
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                exp_mem[bank][32*half + 8*i +: 8] = data[8*i +: 8];
            end
        end
        check_mem(bank, exp_mem[bank]);
    endtask

    task automatic reset_defaults();
        afu_pkg::dev_caps_t exp_caps;
        afu_pkg::dev_caps_t got_caps;
        afu_pkg::data_t     rd;
        exp_caps.fields.reserved      = '0;
        exp_caps.fields.smem_log_size = afu_pkg::SMEM_LOG_SIZE;
        exp_caps.fields.core_count    = afu_pkg::CORE_COUNT;
        exp_caps.fields.warp_count    = afu_pkg::WARP_COUNT;
        exp_caps.fields.thread_count  = 8'(THREAD_CNT);
        exp_caps.fields.impl_id       = afu_pkg::IMPL_ID;
        check_bit("after reset", 1'b0);
        for (int b = 0; b < NUM_BANKS; b++) begin
            check_mem(b, exp_mem[b]);
        end
        // engine idle, nothing started
        axi_read(afu_pkg::ADDR_AP_CTRL, rd);
        check_data("ap_ctrl after reset", rd, 32'h0000_0004);
        axi_read(afu_pkg::ADDR_DEV_0, rd);
        got_caps.words.lo = rd;
        axi_read(afu_pkg::ADDR_DEV_1, rd);
        got_caps.words.hi = rd;
        check_caps("device caps", got_caps, exp_caps);
        axi_read(afu_pkg::ADDR_ISA_0, rd);
        check_data("isa caps low", rd, afu_pkg::ISA_CAPS[31:0]);
        axi_read(afu_pkg::ADDR_ISA_1, rd);
        check_data("isa caps high", rd, afu_pkg::ISA_CAPS[63:32]);
    endtask

    task automatic interrupt_regs();
        afu_pkg::data_t rd;
        set_gie(1'b1);
        axi_read(afu_pkg::ADDR_GIE, rd);
        check_data("gie readback", rd, 32'h1);
        axi_write(afu_pkg::ADDR_IER, 32'h3);
        axi_read(afu_pkg::ADDR_IER, rd);
        check_data("ier readback", rd, 32'h3);
        toggle_status(2'b01);
        toggle_status(2'b11);
        set_gie(1'b0);
        toggle_status(2'b10);
        set_gie(1'b1);
        toggle_status(2'b01);
        toggle_status(2'b01);
    endtask

    task automatic mem_base_writes();
        afu_pkg::data_t data;
        afu_pkg::strb_t strb;
        for (int round = 0; round < 3; round++) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                for (int half = 0; half < 2; half++) begin
                    data = afu_pkg::data_t'($random(seed));
                    strb = afu_pkg::strb_t'($random(seed));
                    write_mem_word(b, half, data, strb, 0);
                end
            end
        end
    endtask

    task automatic kernel_run();
        afu_pkg::data_t rd;
        axi_write(afu_pkg::ADDR_DCR_0, afu_pkg::data_t'(afu_pkg::DCR_KERNEL_LEN));
        axi_write(afu_pkg::ADDR_DCR_1, 32'd40);
        axi_write(afu_pkg::ADDR_IER, 32'h1);
        axi_write(afu_pkg::ADDR_AP_CTRL, 32'h1);
        // start still held and idle low during the run
        axi_read(afu_pkg::ADDR_AP_CTRL, rd);
        check_data("ap_ctrl while running", rd & 32'h85, 32'h01);
        wait_interrupt();
        axi_read(afu_pkg::ADDR_ISR, rd);
        check_data("isr after done", rd, 32'h1);
        axi_read(afu_pkg::ADDR_AP_CTRL, rd);
        check_data("ap_ctrl after done", rd & 32'h85, 32'h04);
        exp_isr = 2'b01;
        toggle_status(2'b01);
    endtask

    task automatic auto_restart_runs();
        afu_pkg::data_t rd;
        axi_write(afu_pkg::ADDR_DCR_1, 32'd60);
        axi_write(afu_pkg::ADDR_AP_CTRL, 32'h81);
        for (int run = 0; run < 3; run++) begin
            wait_interrupt();
            axi_read(afu_pkg::ADDR_AP_CTRL, rd);
            check_data("ap_ctrl under auto-restart", rd & 32'h81, 32'h81);
            exp_isr = 2'b01;
            toggle_status(2'b01);
        end
        // kernel reset stops the chain of runs
        axi_write(afu_pkg::ADDR_AP_CTRL, 32'h10);
        axi_read(afu_pkg::ADDR_AP_CTRL, rd);
        check_data("ap_ctrl after kernel reset", rd & 32'h85, 32'h04);
    endtask

    task automatic back_pressure();
        afu_pkg::data_t data;
        afu_pkg::data_t rd;
        int             bank;
        int             bdelay;
        int             rdelay;
        for (int n = 0; n < 4; n++) begin
            bank   = n % NUM_BANKS;
            data   = afu_pkg::data_t'($random(seed));
            bdelay = ($random(seed) & 7) + 1;
            rdelay = ($random(seed) & 7) + 1;
            write_mem_word(bank, n / NUM_BANKS, data, 4'hF, bdelay);
            axi_read(mem_offset(bank, n / NUM_BANKS), rd, rdelay);
            check_data("memory base after stalled read", rd, data);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests completed");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        seed            = 32'h5dca;
        data_errors     = 0;
        caps_errors     = 0;
        mem_errors      = 0;
        bit_errors      = 0;
        protocol_errors = 0;
        exp_gie         = 1'b0;
        exp_isr         = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            exp_mem[b] = '0;
        end
        awvalid <= 1'b0;
        awaddr  <= '0;
        wvalid  <= 1'b0;
        wdata   <= '0;
        wstrb   <= '0;
        bready  <= 1'b0;
        arvalid <= 1'b0;
        araddr  <= '0;
        rready  <= 1'b0;

        @(negedge reset);
        @(posedge clk);
        reset_defaults();
        interrupt_regs();
        mem_base_writes();
        kernel_run();
        auto_restart_runs();
        back_pressure();
        repeat (2) @(posedge clk);

        $display("errors: data %0d, caps %0d, mem %0d, interrupt %0d, protocol %0d",
                 data_errors, caps_errors, mem_errors, bit_errors, protocol_errors);
        if (data_errors + caps_errors + mem_errors + bit_errors + protocol_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* tb/tb_clock_gen.sv */
/*
 * testbench clock and reset
 * free-running clock, reset held high for a fixed number of cycles
 */
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset is released on a rising edge, like any other synchronous input
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* design/afu_top.sv */
/*
 * accelerator host subsystem
 * axi4-lite control slave with the dcr file and the kernel engine
 */
`timescale 1ns/10ps

module afu_top #(
    parameter int NUM_BANKS  = 2,
    parameter int THREAD_CNT = 4,
    parameter int DCR_DEPTH  = 4
) (
    input  logic                clk,
    input  logic                reset,

    input  logic                awvalid,
    input  afu_pkg::addr_t      awaddr,
    output logic                awready,
    input  logic                wvalid,
    input  afu_pkg::data_t      wdata,
    input  afu_pkg::strb_t      wstrb,
    output logic                wready,
    output logic                bvalid,
    output logic [1:0]          bresp,
    input  logic                bready,
    input  logic                arvalid,
    input  afu_pkg::addr_t      araddr,
    output logic                arready,
    output logic                rvalid,
    output afu_pkg::data_t      rdata,
    output logic [1:0]          rresp,
    input  logic                rready,

    output logic                interrupt,
    output afu_pkg::mem_addr_t  mem_base [NUM_BANKS]
);

    ap_ctrl_if ap_bus ();

    logic               dcr_wr_valid;
    afu_pkg::dcr_addr_t dcr_wr_addr;
    afu_pkg::dcr_data_t dcr_wr_data;
    afu_pkg::dcr_data_t kernel_len;

    afu_ctrl #(
        .NUM_BANKS  (NUM_BANKS),
        .THREAD_CNT (THREAD_CNT)
    ) afu_ctrl_i (
        .clk          (clk),
        .reset        (reset),
        .awvalid      (awvalid),
        .awaddr       (awaddr),
        .awready      (awready),
        .wvalid       (wvalid),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .wready       (wready),
        .bvalid       (bvalid),
        .bresp        (bresp),
        .bready       (bready),
        .arvalid      (arvalid),
        .araddr       (araddr),
        .arready      (arready),
        .rvalid       (rvalid),
        .rdata        (rdata),
        .rresp        (rresp),
        .rready       (rready),
        .ap           (ap_bus.ctrl),
        .interrupt    (interrupt),
        .mem_base     (mem_base),
        .dcr_wr_valid (dcr_wr_valid),
        .dcr_wr_addr  (dcr_wr_addr),
        .dcr_wr_data  (dcr_wr_data)
    );

    dcr_regfile #(
        .DEPTH (DCR_DEPTH)
    ) dcr_regfile_i (
        .clk        (clk),
        .reset      (reset),
        .wr_valid   (dcr_wr_valid),
        .wr_addr    (dcr_wr_addr),
        .wr_data    (dcr_wr_data),
        .kernel_len (kernel_len)
    );

    kernel_engine kernel_engine_i (
        .clk        (clk),
        .reset      (reset),
        .kernel_len (kernel_len),
        .ap         (ap_bus.engine)
    );

endmodule

/* design/kernel_engine.sv */
/*
 * kernel engine
 * idle/run sequencer that counts down the configured work length
 * and answers with a done/ready pulse
 */
`timescale 1ns/10ps

module kernel_engine (
    input  logic               clk,
    input  logic               reset,
    input  afu_pkg::dcr_data_t kernel_len,
    ap_ctrl_if.engine          ap
);

    typedef enum logic {
        ST_IDLE,
        ST_RUN
    } state_t;

    state_t             state;
    afu_pkg::dcr_data_t count;
    logic               last;

    // final cycle of a run, suppressed by a kernel reset
    assign last = (state == ST_RUN) && (count == afu_pkg::dcr_data_t'(1)) && !ap.kernel_reset;

    always_ff @(posedge clk) begin
        if (reset || ap.kernel_reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (ap.start) begin
                        state <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    if (last) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // length is latched at start, zero runs for one cycle
    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            if (kernel_len == '0) begin
                count <= afu_pkg::dcr_data_t'(1);
            end else begin
                count <= kernel_len;
            end
        end else begin
            count <= count - 1'b1;
        end
    end

    assign ap.done  = last;
    assign ap.ready = last;
    assign ap.idle  = (state == ST_IDLE);

endmodule

/* design/dcr_regfile.sv */
/*
 * device configuration register file
 * stores dcr words from single-cycle write pulses and exposes
 * the kernel length word to the engine
 */
`timescale 1ns/10ps

module dcr_regfile #(
    parameter int DEPTH = 4
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               wr_valid,
    input  afu_pkg::dcr_addr_t wr_addr,
    input  afu_pkg::dcr_data_t wr_data,
    output afu_pkg::dcr_data_t kernel_len
);

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    afu_pkg::dcr_data_t regs [DEPTH];
    logic               in_range;

    // words past the end of the file are dropped
    assign in_range = (wr_addr < afu_pkg::dcr_addr_t'(DEPTH));

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_valid && in_range) begin
            regs[wr_addr[IDX_W-1:0]] <= wr_data;
        end
    end

    assign kernel_len = regs[IDX_W'(afu_pkg::DCR_KERNEL_LEN)];

endmodule

/* design/afu_ctrl.sv */
/*
 * afu host control slave
 * axi4-lite register block with kernel control, interrupt registers,
 * capability words, a dcr write port and per-bank memory base addresses
 */
`timescale 1ns/10ps

module afu_ctrl #(
    parameter int NUM_BANKS  = 1,
    parameter int THREAD_CNT = 4
) (
    input  logic                clk,
    input  logic                reset,

    input  logic                awvalid,
    input  afu_pkg::addr_t      awaddr,
    output logic                awready,

    input  logic                wvalid,
    input  afu_pkg::data_t      wdata,
    input  afu_pkg::strb_t      wstrb,
    output logic                wready,

    output logic                bvalid,
    output logic [1:0]          bresp,
    input  logic                bready,

    input  logic                arvalid,
    input  afu_pkg::addr_t      araddr,
    output logic                arready,

    output logic                rvalid,
    output afu_pkg::data_t      rdata,
    output logic [1:0]          rresp,
    input  logic                rready,

    ap_ctrl_if.ctrl             ap,
    output logic                interrupt,

    output afu_pkg::mem_addr_t  mem_base [NUM_BANKS],

    output logic                dcr_wr_valid,
    output afu_pkg::dcr_addr_t  dcr_wr_addr,
    output afu_pkg::dcr_data_t  dcr_wr_data
);

    localparam logic [1:0] RESP_OKAY = 2'b00;

    typedef enum logic [1:0] {
        WS_IDLE,
        WS_DATA,
        WS_RESP
    } wstate_t;

    typedef enum logic {
        RS_IDLE,
        RS_DATA
    } rstate_t;

    wstate_t            wstate;
    rstate_t            rstate;
    afu_pkg::addr_t     waddr;
    afu_pkg::data_t     wmask;
    afu_pkg::data_t     rdata_r;
    afu_pkg::dev_caps_t dev_caps;
    logic               w_fire;
    logic               ar_fire;

    logic               start_r;
    logic               kernel_reset_r;
    logic               auto_restart_r;
    logic               gie_r;
    logic [1:0]         ier_r;
    logic [1:0]         isr_r;
    logic [1:0]         isr_next;
    afu_pkg::dcr_addr_t dcra_r;
    afu_pkg::dcr_data_t dcrv_r;
    logic               dcr_wr_valid_r;
    afu_pkg::mem_addr_t mem_r [NUM_BANKS];

    // capability word is built field by field
    always_comb begin
        dev_caps.fields.reserved      = '0;
        dev_caps.fields.smem_log_size = afu_pkg::SMEM_LOG_SIZE;
        dev_caps.fields.core_count    = afu_pkg::CORE_COUNT;
        dev_caps.fields.warp_count    = afu_pkg::WARP_COUNT;
        dev_caps.fields.thread_count  = 8'(THREAD_CNT);
        dev_caps.fields.impl_id       = afu_pkg::IMPL_ID;
    end

    assign awready = (wstate == WS_IDLE);
    assign wready  = (wstate == WS_DATA);
    assign bvalid  = (wstate == WS_RESP);
    assign bresp   = RESP_OKAY;
    assign w_fire  = wvalid && wready;

    // byte enables widened to a bit mask
    always_comb begin
        for (int i = 0; i < afu_pkg::DATA_W / 8; i++) begin
            wmask[8*i +: 8] = {8{wstrb[i]}};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wstate <= WS_IDLE;
        end else begin
            case (wstate)
                WS_IDLE: if (awvalid) wstate <= WS_DATA;
                WS_DATA: if (wvalid) wstate <= WS_RESP;
                WS_RESP: if (bready) wstate <= WS_IDLE;
                default: wstate <= WS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            waddr <= awaddr;
        end
    end

    // toggle on write, then set by any enabled event
    always_comb begin
        isr_next = isr_r;
        if (w_fire && waddr == afu_pkg::ADDR_ISR && wstrb[0]) begin
            isr_next = isr_r ^ wdata[1:0];
        end
        isr_next = isr_next | {ier_r[1] & ap.ready, ier_r[0] & ap.done};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            start_r        <= 1'b0;
            kernel_reset_r <= 1'b0;
            auto_restart_r <= 1'b0;
            gie_r          <= 1'b0;
            ier_r          <= '0;
            isr_r          <= '0;
            dcra_r         <= '0;
            dcrv_r         <= '0;
            dcr_wr_valid_r <= 1'b0;
            for (int i = 0; i < NUM_BANKS; i++) begin
                mem_r[i] <= '0;
            end
        end else begin
            dcr_wr_valid_r <= 1'b0;
            kernel_reset_r <= 1'b0;
            isr_r          <= isr_next;

            // start clears on the handshake unless auto-restart reloads it
            if (ap.ready) begin
                start_r <= auto_restart_r;
            end

            if (w_fire) begin
                case (waddr)
                    afu_pkg::ADDR_AP_CTRL: begin
                        if (wstrb[0]) begin
                            auto_restart_r <= wdata[7];
                            if (wdata[4]) begin
                                kernel_reset_r <= 1'b1;
                                start_r        <= 1'b0;
                            end else if (wdata[0]) begin
                                start_r <= 1'b1;
                            end
                        end
                    end
                    afu_pkg::ADDR_GIE: begin
                        if (wstrb[0]) gie_r <= wdata[0];
                    end
                    afu_pkg::ADDR_IER: begin
                        if (wstrb[0]) ier_r <= wdata[1:0];
                    end
                    afu_pkg::ADDR_DCR_0: begin
                        dcra_r <= (wdata[afu_pkg::DCR_ADDR_W-1:0]
                                   & wmask[afu_pkg::DCR_ADDR_W-1:0])
                                | (dcra_r & ~wmask[afu_pkg::DCR_ADDR_W-1:0]);
                    end
                    afu_pkg::ADDR_DCR_1: begin
                        dcrv_r         <= (wdata & wmask) | (dcrv_r & ~wmask);
                        dcr_wr_valid_r <= 1'b1;
                    end
                    default: begin
                        for (int i = 0; i < NUM_BANKS; i++) begin
                            if (waddr == afu_pkg::addr_t'(afu_pkg::ADDR_MEM_0
                                                          + i * afu_pkg::MEM_STRIDE)) begin
                                mem_r[i][31:0] <= (wdata & wmask) | (mem_r[i][31:0] & ~wmask);
                            end
                            if (waddr == afu_pkg::addr_t'(afu_pkg::ADDR_MEM_1
                                                          + i * afu_pkg::MEM_STRIDE)) begin
                                mem_r[i][63:32] <= (wdata & wmask)
                                                 | (mem_r[i][63:32] & ~wmask);
                            end
                        end
                    end
                endcase
            end
        end
    end

    assign arready = (rstate == RS_IDLE);
    assign rvalid  = (rstate == RS_DATA);
    assign rresp   = RESP_OKAY;
    assign rdata   = rdata_r;
    assign ar_fire = arvalid && arready;

    always_ff @(posedge clk) begin
        if (reset) begin
            rstate <= RS_IDLE;
        end else begin
            case (rstate)
                RS_IDLE: if (arvalid) rstate <= RS_DATA;
                RS_DATA: if (rready) rstate <= RS_IDLE;
                default: rstate <= RS_IDLE;
            endcase
        end
    end

    // read data is captured with the address and held until rready
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rdata_r <= '0;
            case (araddr)
                afu_pkg::ADDR_AP_CTRL: begin
                    rdata_r[0] <= start_r;
                    rdata_r[1] <= ap.done;
                    rdata_r[2] <= ap.idle;
                    rdata_r[3] <= ap.ready;
                    rdata_r[7] <= auto_restart_r;
                end
                afu_pkg::ADDR_GIE:   rdata_r <= afu_pkg::data_t'(gie_r);
                afu_pkg::ADDR_IER:   rdata_r <= afu_pkg::data_t'(ier_r);
                afu_pkg::ADDR_ISR:   rdata_r <= afu_pkg::data_t'(isr_r);
                afu_pkg::ADDR_DEV_0: rdata_r <= dev_caps.words.lo;
                afu_pkg::ADDR_DEV_1: rdata_r <= dev_caps.words.hi;
                afu_pkg::ADDR_ISA_0: rdata_r <= afu_pkg::ISA_CAPS[31:0];
                afu_pkg::ADDR_ISA_1: rdata_r <= afu_pkg::ISA_CAPS[63:32];
                default: begin
                    // memory bases read back as written
                    for (int i = 0; i < NUM_BANKS; i++) begin
                        if (araddr == afu_pkg::addr_t'(afu_pkg::ADDR_MEM_0
                                                       + i * afu_pkg::MEM_STRIDE)) begin
                            rdata_r <= mem_r[i][31:0];
                        end
                        if (araddr == afu_pkg::addr_t'(afu_pkg::ADDR_MEM_1
                                                       + i * afu_pkg::MEM_STRIDE)) begin
                            rdata_r <= mem_r[i][63:32];
                        end
                    end
                end
            endcase
        end
    end

    assign ap.start        = start_r;
    assign ap.kernel_reset = kernel_reset_r;
    assign interrupt       = gie_r & (|isr_r);
    assign mem_base        = mem_r;
    assign dcr_wr_valid    = dcr_wr_valid_r;
    assign dcr_wr_addr     = dcra_r;
    assign dcr_wr_data     = dcrv_r;

endmodule

/* design/ap_ctrl_if.sv */
/*
 * kernel control handshake
 * start and kernel reset towards the engine, done/ready/idle back
 */
`timescale 1ns/10ps

interface ap_ctrl_if;

    logic start;
    logic kernel_reset;
    // done and ready pulse together for one cycle
    logic done;
    logic ready;
    logic idle;

    modport ctrl (
        output start,
        output kernel_reset,
        input  done,
        input  ready,
        input  idle
    );

    modport engine (
        input  start,
        input  kernel_reset,
        output done,
        output ready,
        output idle
    );

endinterface

/* design/afu_pkg.sv */
/*
 * afu shared definitions
 * register offsets of the host control block, capability constants,
 * bus and DCR widths and the types shared by the design and testbench
 */
package afu_pkg;

    // axi4-lite and dcr widths
    localparam int ADDR_W     = 8;
    localparam int DATA_W     = 32;
    localparam int DCR_ADDR_W = 12;
    localparam int DCR_DATA_W = 32;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [DATA_W/8-1:0]   strb_t;
    typedef logic [DCR_ADDR_W-1:0] dcr_addr_t;
    typedef logic [DCR_DATA_W-1:0] dcr_data_t;
    typedef logic [63:0]           mem_addr_t;

    // host register map
    localparam addr_t ADDR_AP_CTRL = 8'h00;
    localparam addr_t ADDR_GIE     = 8'h04;
    localparam addr_t ADDR_IER     = 8'h08;
    localparam addr_t ADDR_ISR     = 8'h0C;
    localparam addr_t ADDR_DEV_0   = 8'h10;
    localparam addr_t ADDR_DEV_1   = 8'h14;
    localparam addr_t ADDR_ISA_0   = 8'h1C;
    localparam addr_t ADDR_ISA_1   = 8'h20;
    localparam addr_t ADDR_DCR_0   = 8'h28;
    localparam addr_t ADDR_DCR_1   = 8'h2C;
    localparam addr_t ADDR_MEM_0   = 8'h40;
    localparam addr_t ADDR_MEM_1   = 8'h44;
    // distance between the offsets of two memory banks
    localparam int    MEM_STRIDE   = 12;

    // dcr word that sets the kernel work length
    localparam dcr_addr_t DCR_KERNEL_LEN = 12'h001;

    // capability constants
    localparam logic [7:0]  IMPL_ID       = 8'h01;
    localparam logic [7:0]  SMEM_LOG_SIZE = 8'd14;
    localparam logic [15:0] CORE_COUNT    = 16'd4;
    localparam logic [7:0]  WARP_COUNT    = 8'd4;

    // ext bits on top, then xlen code and the base isa bits
    localparam logic [63:0] ISA_CAPS = 64'h0000_1125_4000_1104;

    typedef struct packed {
        logic [15:0] reserved;
        logic [7:0]  smem_log_size;
        logic [15:0] core_count;
        logic [7:0]  warp_count;
        logic [7:0]  thread_count;
        logic [7:0]  impl_id;
    } dev_fields_t;

    typedef struct packed {
        data_t hi;
        data_t lo;
    } dev_words_t;

    // same 64 bits seen as fields or as two bus words
    typedef union packed {
        dev_fields_t fields;
        dev_words_t  words;
    } dev_caps_t;

endpackage
